//--- bus_cases.txt
# rw addr wdata rdata: rw 1 is a write and 0 a read, all values in hex
# a read expects the byte last written to its address
1 0001 a5 00
1 7fff 3c 00
0 0001 00 a5
1 2aaa 81 00
0 7fff 00 3c
1 5555 7e 00
0 2aaa 00 81
1 0001 0f 00
0 5555 00 7e
0 0001 00 0f
1 4000 ff 00
0 4000 00 ff

//--- list.f
bus_master_pkg.sv
shift_if.sv
master_control.sv
serial_shifter.sv
prefix_detector.sv
bus_master.sv
tb_bus_master.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the bus master testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_bus_master
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/Vtb_bus_master
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0

//--- tb_bus_master.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus master testbench: arbiter and slave model, case reader, compare tasks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_bus_master;
    import bus_master_pkg::*;

    localparam int WAIT_LIMIT = 100;  // cycles allowed for any single wait

    logic  clk;
    logic  rstn;
    logic  m_hold;
    logic  m_execute;
    logic  m_rw;
    addr_t m_address;
    data_t m_din;
    data_t m_dout;
    logic  m_dvalid;
    logic  m_busy;
    logic  b_grant;
    logic  b_request;
    logic  b_rw;
    logic  b_bus_utilizing;
    logic  bus_in;
    logic  bus_out;
    logic  bus_oe;

    logic [31:0] lfsr;
    logic        cur_rw;             // direction of the running transaction
    logic        in_txn;
    data_t       slave_mem [addr_t]; // slave storage, filled by writes

    bus_master dut (.*);

    always #5 clk = ~clk;

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        abort_run();
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("Mismatch at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp)
        begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp)
        begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // galois lfsr, one step per bit taken
    function automatic int random_bits(input int count);
        int value;
        value = 0;
        for (int i = 0; i < count; i++)
        begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr  = (lfsr >> 1) ^ (lfsr[0] ? 32'hd0000001 : 32'h0);
        end
        return value;
    endfunction

    function automatic logic probe(input string name);
        case (name)
            "b_request":       return b_request;
            "b_bus_utilizing": return b_bus_utilizing;
            "bus_oe":          return bus_oe;
            "m_dvalid":        return m_dvalid;
            default:           return 1'bx;
        endcase
    endfunction

    task automatic next_cycle();
        if (in_txn)
            check_bit("b_rw", b_rw, cur_rw);  // direction held for the whole transaction
        @(negedge clk);
    endtask

    task automatic wait_signal(input string name, input logic level);
        int n;
        n = 0;
        while (probe(name) !== level)
        begin
            if (n == WAIT_LIMIT)
                report_error($sformatf("timed out waiting for %s to become %b", name, level));
            n++;
            next_cycle();
        end
    endtask

    task automatic acquire_bus();
        int delay;
        m_hold = 1'b1;
        wait_signal("b_request", 1'b1);
        delay = random_bits(3);
        repeat (delay)
        begin
            check_bit("b_bus_utilizing", b_bus_utilizing, 1'b0);  // no use before the grant
            next_cycle();
        end
        check_bit("b_bus_utilizing", b_bus_utilizing, 1'b0);
        b_grant = 1'b1;
        wait_signal("b_bus_utilizing", 1'b1);
    endtask

    task automatic release_bus();
        m_hold = 1'b0;
        wait_signal("b_bus_utilizing", 1'b0);
        check_bit("b_request", b_request, 1'b0);
        b_grant = 1'b0;
    endtask

    // bits sampled while bus_oe is high, MSB first into the low end
    task automatic collect_bits(input int count, output addr_t word);
        word = '0;
        wait_signal("bus_oe", 1'b1);
        for (int i = 0; i < count; i++)
        begin
            check_bit("bus_oe", bus_oe, 1'b1);
            word = {word[ADDR_W-2:0], bus_out};
            m_execute = (i == 3) && (count == ADDR_W);  // stray strobe while busy
            next_cycle();
        end
        m_execute = 1'b0;
        check_bit("bus_oe", bus_oe, 1'b0);
    endtask

    task automatic send_prefix(input logic [1:0] pattern);
        int gap;
        gap = random_bits(2);
        repeat (gap)
        begin
            check_bit("m_dvalid", m_dvalid, 1'b0);
            next_cycle();
        end
        check_bit("m_dvalid", m_dvalid, 1'b0);
        bus_in = pattern[1];
        next_cycle();
        check_bit("m_dvalid", m_dvalid, 1'b0);
        bus_in = pattern[0];
        next_cycle();
        bus_in = 1'b1;
    endtask

    task automatic run_case(input logic rw, input addr_t addr, input data_t wdata,
                            input data_t rdata);
        addr_t word;
        data_t bits;
        m_rw      = rw;
        m_address = addr;
        m_din     = wdata;
        m_execute = 1'b1;
        cur_rw    = rw;
        @(negedge clk);
        m_execute = 1'b0;
        m_address = ~addr;  // a later strobe must not pick this up
        in_txn    = 1'b1;
        check_bit("m_busy", m_busy, 1'b1);
        collect_bits(ADDR_W, word);
        check_addr("address", word, addr);
        send_prefix(ADDR_ACK_PREFIX);
        if (rw)
        begin
            collect_bits(DATA_W, word);
            check_data("write data", data_t'(word), wdata);
            slave_mem[addr] = data_t'(word);
            send_prefix(DATA_PREFIX);
        end
        else
        begin
            if (!slave_mem.exists(addr))
                report_error("read of an address the slave never wrote");
            bits = slave_mem[addr];
            send_prefix(DATA_PREFIX);
            for (int i = 0; i < DATA_W; i++)
            begin
                bus_in = bits[DATA_W-1];
                bits   = bits << 1;
                next_cycle();
            end
            bus_in = 1'b1;
        end
        wait_signal("m_dvalid", 1'b1);
        check_bit("m_busy", m_busy, 1'b0);
        if (!rw)
            check_data("m_dout", m_dout, rdata);
        in_txn = 1'b0;
        repeat (3)
        begin
            next_cycle();
            check_bit("m_dvalid", m_dvalid, 1'b0);
            check_bit("bus_oe", bus_oe, 1'b0);  // no second address phase
        end
    endtask

    initial
    begin
        int    fd;
        int    ncase;
        string line;
        logic  rw;
        addr_t addr;
        data_t wdata;
        data_t rdata;
        clk       = 1'b0;
        rstn      = 1'b0;
        m_hold    = 1'b0;
        m_execute = 1'b0;
        m_rw      = 1'b0;
        m_address = '0;
        m_din     = '0;
        b_grant   = 1'b0;
        bus_in    = 1'b1;  // line idles high
        lfsr      = 32'h4859a71e;
        cur_rw    = 1'b0;
        in_txn    = 1'b0;
        ncase     = 0;
        repeat (16) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        check_bit("b_request", b_request, 1'b0);
        check_bit("m_busy", m_busy, 1'b0);
        check_bit("m_dvalid", m_dvalid, 1'b0);
        check_bit("bus_oe", bus_oe, 1'b0);
        check_bit("b_bus_utilizing", b_bus_utilizing, 1'b0);
        fd = $fopen("bus_cases.txt", "r");
        if (fd == 0)
            report_error("cannot open bus_cases.txt");
        acquire_bus();
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 3 && line[0] != "#")
            begin
                if ($sscanf(line, "%h %h %h %h", rw, addr, wdata, rdata) != 4)
                    report_error({"unreadable case line: ", line});
                if (ncase > 0 && ncase % 3 == 0)
                begin
                    release_bus();  // next case must win the bus again
                    acquire_bus();
                end
                run_case(rw, addr, wdata, rdata);
                ncase++;
            end
        end
        $fclose(fd);
        release_bus();
        if (ncase == 0)
            report_error("no cases found in bus_cases.txt");
        else
        begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

//--- bus_master.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// serial bus master top level, controller with shifter and prefix detector
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module bus_master (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  m_hold,
    input  logic                  m_execute,
    input  logic                  m_rw,
    input  bus_master_pkg::addr_t m_address,
    input  bus_master_pkg::data_t m_din,
    output bus_master_pkg::data_t m_dout,
    output logic                  m_dvalid,
    output logic                  m_busy,
    input  logic                  b_grant,
    output logic                  b_request,
    output logic                  b_rw,
    output logic                  b_bus_utilizing,
    input  logic                  bus_in,
    output logic                  bus_out,
    output logic                  bus_oe
);
    import bus_master_pkg::*;

    shift_if sh ();

    logic listen;
    logic addr_ack;
    logic data_prefix;

    master_control u_ctrl (
        .clk             (clk),
        .rstn            (rstn),
        .m_hold          (m_hold),
        .m_execute       (m_execute),
        .m_rw            (m_rw),
        .m_address       (m_address),
        .m_din           (m_din),
        .m_dout          (m_dout),
        .m_dvalid        (m_dvalid),
        .m_busy          (m_busy),
        .b_grant         (b_grant),
        .b_request       (b_request),
        .b_rw            (b_rw),
        .b_bus_utilizing (b_bus_utilizing),
        .bus_oe          (bus_oe),
        .listen          (listen),
        .addr_ack        (addr_ack),
        .data_prefix     (data_prefix),
        .sh              (sh.ctrl)
    );

    serial_shifter u_shift (
        .clk     (clk),
        .rstn    (rstn),
        .bus_in  (bus_in),
        .bus_out (bus_out),
        .sh      (sh.engine)
    );

    prefix_detector u_prefix (
        .clk         (clk),
        .rstn        (rstn),
        .listen      (listen),
        .bus_in      (bus_in),
        .addr_ack    (addr_ack),
        .data_prefix (data_prefix)
    );

endmodule

//--- prefix_detector.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two-bit reply prefix watcher on the incoming line
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module prefix_detector (
    input  logic clk,
    input  logic rstn,
    input  logic listen,
    input  logic bus_in,
    output logic addr_ack,
    output logic data_prefix
);
    import bus_master_pkg::*;

    logic prev_q;  // line bit of the previous cycle

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            prev_q <= 1'b1;
        else if (listen)
            prev_q <= bus_in;
        else
            prev_q <= 1'b1;  // idle level, no stale match across phases
    end

    assign addr_ack    = ({prev_q, bus_in} == ADDR_ACK_PREFIX);
    assign data_prefix = ({prev_q, bus_in} == DATA_PREFIX);

endmodule

//--- serial_shifter.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two-way parallel/serial shift engine, MSB first
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module serial_shifter (
    input  logic    clk,
    input  logic    rstn,
    input  logic    bus_in,
    output logic    bus_out,
    shift_if.engine sh
);
    import bus_master_pkg::*;

    addr_t      shift_q;
    bit_count_t count_q;  // bits still to go
    bit_count_t len_q;    // length of the running receive
    logic       tx_busy;
    logic       rx_busy;
    addr_t      rx_full;

    assign bus_out = shift_q[ADDR_W-1];

    assign sh.tx_done = tx_busy && (count_q == bit_count_t'(1));
    assign sh.rx_done = rx_busy && (count_q == bit_count_t'(1));

    // last bit is still on the line during rx_done
    assign rx_full    = {shift_q[ADDR_W-2:0], bus_in};
    assign sh.rx_word = rx_full << (bit_count_t'(ADDR_W) - len_q);

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            tx_busy <= 1'b0;
            rx_busy <= 1'b0;
            count_q <= '0;
        end
        else if (sh.load)
        begin
            tx_busy <= 1'b1;
            count_q <= sh.bit_count;
        end
        else if (sh.rx_en)
        begin
            rx_busy <= 1'b1;
            count_q <= sh.bit_count;
        end
        else if (tx_busy || rx_busy)
        begin
            count_q <= count_q - bit_count_t'(1);
            if (count_q == bit_count_t'(1))
            begin
                tx_busy <= 1'b0;
                rx_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (sh.load)
            shift_q <= sh.tx_word;
        else if (tx_busy)
            shift_q <= {shift_q[ADDR_W-2:0], 1'b0};
        else if (rx_busy)
            shift_q <= rx_full;  // fill from the bottom
        if (sh.rx_en)
            len_q <= sh.bit_count;
    end

    // the controller starts one shift at a time and never overlaps them
    a_one_shift: assert property (@(posedge clk) disable iff (!rstn)
        (sh.load || sh.rx_en) |-> !(sh.load && sh.rx_en) && !tx_busy && !rx_busy);

endmodule

//--- master_control.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus master FSM: request and grant, address, acknowledge and data phases
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module master_control (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  m_hold,
    input  logic                  m_execute,
    input  logic                  m_rw,
    input  bus_master_pkg::addr_t m_address,
    input  bus_master_pkg::data_t m_din,
    output bus_master_pkg::data_t m_dout,
    output logic                  m_dvalid,
    output logic                  m_busy,
    input  logic                  b_grant,
    output logic                  b_request,
    output logic                  b_rw,
    output logic                  b_bus_utilizing,
    output logic                  bus_oe,
    output logic                  listen,
    input  logic                  addr_ack,
    input  logic                  data_prefix,
    shift_if.ctrl                 sh
);
    import bus_master_pkg::*;

    master_state_e state;
    logic          rw_q;     // 1 write, 0 read
    data_t         wdata_q;
    logic          accept;

    assign accept = (state == ST_GRANTED) && m_hold && b_grant && m_execute && !m_busy;

    // the load cycle itself puts nothing on the line
    assign bus_oe = ((state == ST_ADDR_SEND) || (state == ST_WRITE)) && !sh.load;
    assign b_rw   = rw_q && b_bus_utilizing;  // reads as 0 when the bus is not ours

    // data bits follow right after the 1 of the prefix
    assign sh.rx_en = (state == ST_READ_WAIT) && data_prefix;

    // drop listen on a match so the next phase starts from the idle level
    assign listen = ((state == ST_ADDR_ACK) && !addr_ack)
                 || ((state == ST_DATA_ACK) && !data_prefix)
                 || ((state == ST_READ_WAIT) && !data_prefix);

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state           <= ST_IDLE;
            b_request       <= 1'b0;
            b_bus_utilizing <= 1'b0;
            m_busy          <= 1'b0;
            m_dvalid        <= 1'b0;
            sh.load         <= 1'b0;
            rw_q            <= 1'b0;
        end
        else
        begin
            m_dvalid <= 1'b0;  // single-cycle strobes
            sh.load  <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (m_hold)
                    begin
                        b_request <= 1'b1;
                        state     <= ST_REQUEST;
                    end
                end
                ST_REQUEST:
                begin
                    if (!m_hold)
                    begin
                        b_request <= 1'b0;  // module gave up before the grant
                        state     <= ST_IDLE;
                    end
                    else if (b_grant)
                    begin
                        b_bus_utilizing <= 1'b1;
                        state           <= ST_GRANTED;
                    end
                end
                ST_GRANTED:
                begin
                    if (!m_hold)
                    begin
                        b_request       <= 1'b0;
                        b_bus_utilizing <= 1'b0;
                        state           <= ST_IDLE;
                    end
                    else if (!b_grant)
                    begin
                        b_bus_utilizing <= 1'b0;  // keep requesting
                        state           <= ST_REQUEST;
                    end
                    else if (accept)
                    begin
                        rw_q    <= m_rw;
                        m_busy  <= 1'b1;
                        sh.load <= 1'b1;
                        state   <= ST_ADDR_SEND;
                    end
                end
                ST_ADDR_SEND:
                begin
                    if (sh.tx_done)
                        state <= ST_ADDR_ACK;
                end
                ST_ADDR_ACK:
                begin
                    if (addr_ack)
                    begin
                        sh.load <= rw_q;
                        state   <= rw_q ? ST_WRITE : ST_READ_WAIT;
                    end
                end
                ST_WRITE:
                begin
                    if (sh.tx_done)
                        state <= ST_DATA_ACK;
                end
                ST_DATA_ACK:
                begin
                    if (data_prefix)
                    begin
                        m_dvalid <= 1'b1;
                        m_busy   <= 1'b0;
                        state    <= ST_GRANTED;
                    end
                end
                ST_READ_WAIT:
                begin
                    if (data_prefix)
                        state <= ST_READ;
                end
                ST_READ:
                begin
                    if (sh.rx_done)
                    begin
                        m_dvalid <= 1'b1;
                        m_busy   <= 1'b0;
                        state    <= ST_GRANTED;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            sh.tx_word   <= m_address;
            sh.bit_count <= bit_count_t'(ADDR_W);
            wdata_q      <= m_din;
        end
        else if ((state == ST_ADDR_ACK) && addr_ack)
        begin
            sh.tx_word   <= {wdata_q, {(ADDR_W - DATA_W){1'b0}}};  // byte in the top bits
            sh.bit_count <= bit_count_t'(DATA_W);
        end
        if ((state == ST_READ) && sh.rx_done)
            m_dout <= sh.rx_word[ADDR_W-1 -: DATA_W];
    end

    // arbiter must not take the bus back inside a transaction
    a_grant_held: assert property (@(posedge clk) disable iff (!rstn)
        accept |=> (b_grant throughout m_dvalid[->1]));

endmodule

//--- shift_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// controller to serial shifter interface
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface shift_if;

    logic                       load;       // start a transmit
    logic                       rx_en;      // start a receive
    bus_master_pkg::bit_count_t bit_count;
    bus_master_pkg::addr_t      tx_word;    // left-justified
    bus_master_pkg::addr_t      rx_word;    // left-justified
    logic                       tx_done;
    logic                       rx_done;

    modport ctrl (
        output load,
        output rx_en,
        output bit_count,
        output tx_word,
        input  rx_word,
        input  tx_done,
        input  rx_done
    );

    modport engine (
        input  load,
        input  rx_en,
        input  bit_count,
        input  tx_word,
        output rx_word,
        output tx_done,
        output rx_done
    );

endinterface

//--- bus_master_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus master widths, vector types, controller states, serial reply prefixes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package bus_master_pkg;

    localparam int DATA_W = 8;   // one data byte
    localparam int ADDR_W = 15;  // slave address, also the shifter word

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [3:0]        bit_count_t;  // bits in one shift, up to 15

    // reply patterns on the line, held bit first
    localparam logic [1:0] ADDR_ACK_PREFIX = 2'b00;  // slave took the address
    localparam logic [1:0] DATA_PREFIX     = 2'b01;  // read data starts or write taken

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_REQUEST,    // waiting for the arbiter
        ST_GRANTED,    // bus owned, ready for a command
        ST_ADDR_SEND,
        ST_ADDR_ACK,
        ST_WRITE,
        ST_DATA_ACK,
        ST_READ_WAIT,  // listening for the data start
        ST_READ
    } master_state_e;

endpackage
